// File: hdl/sim_mon_pkg.sv
// simulation monitor package with snoop addresses, widths, opcodes and the instruction word views
package sim_mon_pkg;

  // axi snoop widths
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  localparam int ID_W   = 2;
  localparam int N_IDS  = 4;

  // per-id console store
  localparam int LINE_DEPTH = 8;
  localparam int PTR_W      = $clog2(LINE_DEPTH);
  // one extra bit so a full store is representable
  localparam int FILL_W     = PTR_W + 1;
  localparam logic [FILL_W-1:0] LINE_FULL = FILL_W'(LINE_DEPTH);

  // monitored addresses
  localparam logic [ADDR_W-1:0] STDERR_ADDR = 32'hFFFF_0000;
  localparam logic [ADDR_W-1:0] STDIO_ADDR  = 32'hFFFF_0004;
  localparam logic [ADDR_W-1:0] EOC_ADDR    = 32'hCC03_0000;

  localparam logic [7:0] CHAR_NEWLINE = 8'd10;

  // counter and timer widths
  localparam int CNT_W  = 8;
  localparam int TIME_W = 32;

  // instruction decode constants
  localparam logic [6:0]  OPC_OPIMM      = 7'h13;
  localparam logic [6:0]  OPC_AMO        = 7'h2F;
  localparam logic [6:0]  OPC_FSYNC      = 7'h5B;
  localparam logic [11:0] SENTINEL_IMM   = 12'h505;
  localparam logic [4:0]  AMO_FUNCT5_ADD = 5'd0;
  localparam logic [2:0]  FUNCT3_WORD    = 3'd2;

  // one instruction word, seen as i-type or as amo
  typedef union packed {
    struct packed {
      logic [11:0] imm;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } itype;
    struct packed {
      logic [4:0] funct5;
      logic       aq;
      logic       rl;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
    } amo;
  } instr_word_u;

endpackage

// File: hdl/write_decoder.sv
// write decoder that turns snooped AW/W beats into character, error and exit-code events
`timescale 1ns/1ps

module write_decoder (
  input  logic                             clk,
  input  logic                             reset_i,
  input  logic                             aw_valid_i,
  input  logic [sim_mon_pkg::ADDR_W-1:0]   aw_addr_i,
  input  logic [sim_mon_pkg::ID_W-1:0]     aw_id_i,
  input  logic                             w_valid_i,
  input  logic [sim_mon_pkg::DATA_W-1:0]   w_data_i,
  output logic                             char_valid_o,
  output logic [7:0]                       char_data_o,
  output logic [sim_mon_pkg::ID_W-1:0]     char_id_o,
  output logic                             err_valid_o,
  output logic [7:0]                       err_code_o,
  output logic                             eoc_valid_o,
  output logic [15:0]                      eoc_code_o
);

  logic pend_char, pend_err, pend_eoc, pend_any;
  logic hit_char, hit_err, hit_eoc;
  logic fire_char, fire_err, fire_eoc;
  logic [sim_mon_pkg::ID_W-1:0] pend_id;

  // address match on the aw channel
  assign hit_char = aw_valid_i && (aw_addr_i == sim_mon_pkg::STDIO_ADDR);
  assign hit_err  = aw_valid_i && (aw_addr_i == sim_mon_pkg::STDERR_ADDR);
  assign hit_eoc  = aw_valid_i && (aw_addr_i == sim_mon_pkg::EOC_ADDR);
  assign pend_any = pend_char || pend_err || pend_eoc;

  // a w beat closes an older pending aw first
  // same-cycle aw only counts when nothing is pending
  assign fire_err  = w_valid_i && (pend_err || (!pend_any && hit_err));
  assign fire_eoc  = w_valid_i && !pend_err && (pend_eoc || (!pend_any && hit_eoc));
  assign fire_char = w_valid_i && !pend_err && !pend_eoc &&
                     (pend_char || (!pend_any && hit_char));

  always_ff @(posedge clk) begin
    if (reset_i) begin
      pend_char    <= 1'b0;
      pend_err     <= 1'b0;
      pend_eoc     <= 1'b0;
      pend_id      <= '0;
      char_valid_o <= 1'b0;
      err_valid_o  <= 1'b0;
      eoc_valid_o  <= 1'b0;
      char_data_o  <= '0;
      char_id_o    <= '0;
      err_code_o   <= '0;
      eoc_code_o   <= '0;
    end else begin
      // new aw stays armed unless its own beat came along
      pend_char <= hit_char ? !(fire_char && !pend_char) : (pend_char && !fire_char);
      pend_err  <= hit_err  ? !(fire_err && !pend_err)   : (pend_err && !fire_err);
      pend_eoc  <= hit_eoc  ? !(fire_eoc && !pend_eoc)   : (pend_eoc && !fire_eoc);
      if (hit_char) begin
        pend_id <= aw_id_i;
      end
      // registered event pulses
      char_valid_o <= fire_char;
      err_valid_o  <= fire_err;
      eoc_valid_o  <= fire_eoc;
      char_data_o  <= w_data_i[7:0];
      // id from the latched aw, or the aw of this very cycle
      char_id_o    <= pend_char ? pend_id : aw_id_i;
      err_code_o   <= w_data_i[7:0];
      eoc_code_o   <= w_data_i[15:0];
    end
  end

  // one beat yields one event
  a_one_event: assert property (@(posedge clk) disable iff (reset_i)
    $onehot0({char_valid_o, err_valid_o, eoc_valid_o}));

endmodule

// File: hdl/line_buffer.sv
// console line buffer that stores characters per write id and drains a line on newline
`timescale 1ns/1ps

module line_buffer (
  input  logic                          clk,
  input  logic                          reset_i,
  input  logic                          char_valid_i,
  input  logic [7:0]                    char_data_i,
  input  logic [sim_mon_pkg::ID_W-1:0]  char_id_i,
  output logic                          line_valid_o,
  output logic [7:0]                    line_char_o,
  output logic [sim_mon_pkg::ID_W-1:0]  line_id_o,
  output logic                          overflow_o
);

  // character store, one row per id
  logic [7:0] line_mem [sim_mon_pkg::N_IDS][sim_mon_pkg::LINE_DEPTH];
  logic [sim_mon_pkg::FILL_W-1:0] fill_cnt [sim_mon_pkg::N_IDS];
  logic [sim_mon_pkg::N_IDS-1:0]  flush_req;

  // drain state
  logic                          draining;
  logic [sim_mon_pkg::ID_W-1:0]  drain_id;
  logic [sim_mon_pkg::PTR_W-1:0] drain_ptr;
  logic [sim_mon_pkg::PTR_W-1:0] drain_last;

  logic                          wr_full;
  logic                          last_char;
  logic [sim_mon_pkg::ID_W-1:0]  pick_id;
  logic [sim_mon_pkg::FILL_W-1:0] pick_len_m1;

  assign wr_full     = fill_cnt[char_id_i] == sim_mon_pkg::LINE_FULL;
  assign last_char   = drain_ptr == drain_last;
  assign pick_len_m1 = fill_cnt[pick_id] - 1'b1;

  // lowest queued id wins
  always_comb begin
    pick_id = '0;
    for (int i = sim_mon_pkg::N_IDS - 1; i >= 0; i--) begin
      if (flush_req[i]) begin
        pick_id = i[sim_mon_pkg::ID_W-1:0];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset_i) begin
      for (int i = 0; i < sim_mon_pkg::N_IDS; i++) begin
        for (int j = 0; j < sim_mon_pkg::LINE_DEPTH; j++) begin
          line_mem[i][j] <= '0;
        end
      end
    end else if (char_valid_i && !wr_full) begin
      line_mem[char_id_i][fill_cnt[char_id_i][sim_mon_pkg::PTR_W-1:0]] <= char_data_i;
    end
  end

  always_ff @(posedge clk) begin
    if (reset_i) begin
      for (int i = 0; i < sim_mon_pkg::N_IDS; i++) begin
        fill_cnt[i] <= '0;
      end
      flush_req  <= '0;
      draining   <= 1'b0;
      drain_id   <= '0;
      drain_ptr  <= '0;
      drain_last <= '0;
      overflow_o <= 1'b0;
    end else begin
      // full store drops the char
      overflow_o <= char_valid_i && wr_full;
      if (char_valid_i && !wr_full) begin
        fill_cnt[char_id_i] <= fill_cnt[char_id_i] + 1'b1;
      end
      if (draining) begin
        if (last_char) begin
          draining           <= 1'b0;
          fill_cnt[drain_id] <= '0;
        end else begin
          drain_ptr <= drain_ptr + 1'b1;
        end
      end else if (|flush_req) begin
        flush_req[pick_id] <= 1'b0;
        drain_id           <= pick_id;
        drain_ptr          <= '0;
        drain_last         <= pick_len_m1[sim_mon_pkg::PTR_W-1:0];
        // an empty store just retires the request
        draining           <= fill_cnt[pick_id] != '0;
      end
      // newline queues a flush even if it was dropped
      if (char_valid_i && (char_data_i == sim_mon_pkg::CHAR_NEWLINE)) begin
        flush_req[char_id_i] <= 1'b1;
      end
    end
  end

  assign line_valid_o = draining;
  assign line_char_o  = line_mem[drain_id][drain_ptr];
  assign line_id_o    = drain_id;

  // never drain an empty store
  a_drain_nonempty: assert property (@(posedge clk) disable iff (reset_i)
    line_valid_o |-> (fill_cnt[drain_id] != '0));

endmodule

// File: hdl/instr_classifier.sv
// instruction classifier that counts sentinel, amo sync and fsync instructions
`timescale 1ns/1ps

module instr_classifier (
  input  logic                           clk,
  input  logic                           reset_i,
  input  logic                           instr_valid_i,
  input  logic [31:0]                    instr_i,
  output logic [sim_mon_pkg::CNT_W-1:0]  sentinel_count_o,
  output logic [sim_mon_pkg::CNT_W-1:0]  sync_count_o,
  output logic [sim_mon_pkg::CNT_W-1:0]  fsync_count_o,
  output logic                           sentinel_hit_o
);

  sim_mon_pkg::instr_word_u instr_w;
  logic is_sentinel, is_sync, is_fsync;

  assign instr_w = instr_i;

  // addi x0, x0, 0x505
  assign is_sentinel = (instr_w.itype.opcode == sim_mon_pkg::OPC_OPIMM) &&
                       (instr_w.itype.rd == '0) && (instr_w.itype.rs1 == '0) &&
                       (instr_w.itype.funct3 == '0) &&
                       (instr_w.itype.imm == sim_mon_pkg::SENTINEL_IMM);
  // amoadd.w
  assign is_sync = (instr_w.amo.opcode == sim_mon_pkg::OPC_AMO) &&
                   (instr_w.amo.funct5 == sim_mon_pkg::AMO_FUNCT5_ADD) &&
                   (instr_w.amo.funct3 == sim_mon_pkg::FUNCT3_WORD);
  // custom opcode only
  assign is_fsync = instr_w.itype.opcode == sim_mon_pkg::OPC_FSYNC;

  always_ff @(posedge clk) begin
    if (reset_i) begin
      sentinel_count_o <= '0;
      sync_count_o     <= '0;
      fsync_count_o    <= '0;
      sentinel_hit_o   <= 1'b0;
    end else begin
      sentinel_hit_o <= instr_valid_i && is_sentinel;
      // saturating counts
      if (instr_valid_i && is_sentinel && (sentinel_count_o != '1)) begin
        sentinel_count_o <= sentinel_count_o + 1'b1;
      end
      if (instr_valid_i && is_sync && (sync_count_o != '1)) begin
        sync_count_o <= sync_count_o + 1'b1;
      end
      if (instr_valid_i && is_fsync && (fsync_count_o != '1)) begin
        fsync_count_o <= fsync_count_o + 1'b1;
      end
    end
  end

  a_one_class: assert property (@(posedge clk) disable iff (reset_i)
    instr_valid_i |-> $onehot0({is_sentinel, is_sync, is_fsync}));

endmodule

// File: hdl/status_regs.sv
// status registers for error byte, exit code, overflow, cycle timer and sentinel stamp
`timescale 1ns/1ps

module status_regs (
  input  logic                            clk,
  input  logic                            reset_i,
  input  logic                            err_valid_i,
  input  logic [7:0]                      err_code_i,
  input  logic                            eoc_valid_i,
  input  logic [15:0]                     eoc_code_i,
  input  logic                            overflow_i,
  input  logic                            sentinel_hit_i,
  output logic [7:0]                      err_code_o,
  output logic [15:0]                     exit_code_o,
  output logic                            eoc_o,
  output logic                            overflow_o,
  output logic [sim_mon_pkg::TIME_W-1:0]  timer_o,
  output logic [sim_mon_pkg::TIME_W-1:0]  sentinel_time_o
);

  always_ff @(posedge clk) begin
    if (reset_i) begin
      err_code_o      <= '0;
      exit_code_o     <= '0;
      eoc_o           <= 1'b0;
      overflow_o      <= 1'b0;
      timer_o         <= '0;
      sentinel_time_o <= '0;
    end else begin
      // free-running cycle count
      timer_o <= timer_o + 1'b1;
      // last error byte
      if (err_valid_i) begin
        err_code_o <= err_code_i;
      end
      if (eoc_valid_i) begin
        exit_code_o <= eoc_code_i;
      end
      // sticky end of computation
      // a zero code does not count as done
      if (eoc_valid_i && (eoc_code_i != '0)) begin
        eoc_o <= 1'b1;
      end
      // sticky once any char was dropped
      if (overflow_i) begin
        overflow_o <= 1'b1;
      end
      // stamp of the latest sentinel
      if (sentinel_hit_i) begin
        sentinel_time_o <= timer_o;
      end
    end
  end

endmodule

// File: hdl/sim_mon_top.sv
// simulation monitor top level joining the write decoder, line buffer, classifier and status
`timescale 1ns/1ps

module sim_mon_top (
  input  logic                            clk,
  input  logic                            reset_i,
  input  logic                            aw_valid_i,
  input  logic [sim_mon_pkg::ADDR_W-1:0]  aw_addr_i,
  input  logic [sim_mon_pkg::ID_W-1:0]    aw_id_i,
  input  logic                            w_valid_i,
  input  logic [sim_mon_pkg::DATA_W-1:0]  w_data_i,
  input  logic                            instr_valid_i,
  input  logic [31:0]                     instr_i,
  output logic                            line_valid_o,
  output logic [7:0]                      line_char_o,
  output logic [sim_mon_pkg::ID_W-1:0]    line_id_o,
  output logic [sim_mon_pkg::CNT_W-1:0]   sentinel_count_o,
  output logic [sim_mon_pkg::CNT_W-1:0]   sync_count_o,
  output logic [sim_mon_pkg::CNT_W-1:0]   fsync_count_o,
  output logic [7:0]                      err_code_o,
  output logic [15:0]                     exit_code_o,
  output logic                            eoc_o,
  output logic                            overflow_o,
  output logic [sim_mon_pkg::TIME_W-1:0]  timer_o,
  output logic [sim_mon_pkg::TIME_W-1:0]  sentinel_time_o
);

  // decoder to line buffer
  logic                         char_valid;
  logic [7:0]                   char_data;
  logic [sim_mon_pkg::ID_W-1:0] char_id;
  // decoder to status
  logic                         err_valid;
  logic [7:0]                   err_code;
  logic                         eoc_valid;
  logic [15:0]                  eoc_code;
  logic                         overflow;
  logic                         sentinel_hit;

  write_decoder write_decoder_inst (
    .clk          (clk),
    .reset_i      (reset_i),
    .aw_valid_i   (aw_valid_i),
    .aw_addr_i    (aw_addr_i),
    .aw_id_i      (aw_id_i),
    .w_valid_i    (w_valid_i),
    .w_data_i     (w_data_i),
    .char_valid_o (char_valid),
    .char_data_o  (char_data),
    .char_id_o    (char_id),
    .err_valid_o  (err_valid),
    .err_code_o   (err_code),
    .eoc_valid_o  (eoc_valid),
    .eoc_code_o   (eoc_code)
  );

  line_buffer line_buffer_inst (
    .clk          (clk),
    .reset_i      (reset_i),
    .char_valid_i (char_valid),
    .char_data_i  (char_data),
    .char_id_i    (char_id),
    .line_valid_o (line_valid_o),
    .line_char_o  (line_char_o),
    .line_id_o    (line_id_o),
    .overflow_o   (overflow)
  );

  instr_classifier instr_classifier_inst (
    .clk              (clk),
    .reset_i          (reset_i),
    .instr_valid_i    (instr_valid_i),
    .instr_i          (instr_i),
    .sentinel_count_o (sentinel_count_o),
    .sync_count_o     (sync_count_o),
    .fsync_count_o    (fsync_count_o),
    .sentinel_hit_o   (sentinel_hit)
  );

  status_regs status_regs_inst (
    .clk             (clk),
    .reset_i         (reset_i),
    .err_valid_i     (err_valid),
    .err_code_i      (err_code),
    .eoc_valid_i     (eoc_valid),
    .eoc_code_i      (eoc_code),
    .overflow_i      (overflow),
    .sentinel_hit_i  (sentinel_hit),
    .err_code_o      (err_code_o),
    .exit_code_o     (exit_code_o),
    .eoc_o           (eoc_o),
    .overflow_o      (overflow_o),
    .timer_o         (timer_o),
    .sentinel_time_o (sentinel_time_o)
  );

endmodule

// File: bench/sim_mon_checker.sv
// monitor checker that gathers released lines and compares the DUT outputs with expectations
`timescale 1ns/1ps

module sim_mon_checker (
  input  logic                            clk,
  input  logic                            reset_i,
  input  logic                            line_valid_i,
  input  logic [7:0]                      line_char_i,
  input  logic [sim_mon_pkg::ID_W-1:0]    line_id_i,
  input  logic [sim_mon_pkg::CNT_W-1:0]   sentinel_count_i,
  input  logic [sim_mon_pkg::CNT_W-1:0]   sync_count_i,
  input  logic [sim_mon_pkg::CNT_W-1:0]   fsync_count_i,
  input  logic [7:0]                      err_code_i,
  input  logic [15:0]                     exit_code_i,
  input  logic                            eoc_i,
  input  logic                            overflow_i,
  input  logic [sim_mon_pkg::TIME_W-1:0]  timer_i,
  input  logic [sim_mon_pkg::TIME_W-1:0]  sentinel_time_i,
  input  logic                            exp_valid_i,
  input  logic [7:0]                      exp_kind_i,
  input  logic [7:0]                      exp_id_i,
  input  logic [31:0]                     exp_a_i,
  input  logic [31:0]                     exp_b_i,
  output logic                            pending_o,
  output int                              check_count_o,
  output int                              error_count_o,
  output int                              test_count_o,
  output int                              test_fail_o
);

  // released characters per id
  // a line never exceeds the store
  logic [7:0]  got_mem [sim_mon_pkg::N_IDS][sim_mon_pkg::LINE_DEPTH];
  int          got_cnt [sim_mon_pkg::N_IDS];
  // one outstanding line per id
  logic [63:0] exp_line [sim_mon_pkg::N_IDS];
  int          exp_len [sim_mon_pkg::N_IDS];
  logic [sim_mon_pkg::N_IDS-1:0] line_pend;
  // ids in the order their drains started
  logic [3:0]  order_log [8];
  int          order_cnt;
  logic        prev_valid;
  logic [sim_mon_pkg::TIME_W-1:0] last_stamp;
  int          test_errors;
  // clock cycles seen since reset went low
  int          elapsed;

  assign pending_o = |line_pend;

  // chars sit left aligned and the first zero byte ends the line
  function automatic int line_length(input logic [63:0] chars);
    int len;
    len = 0;
    for (int i = 7; i >= 0; i--) begin
      if (chars[i*8 +: 8] == 8'h00) begin
        break;
      end
      len++;
    end
    return len;
  endfunction

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] expected);
    check_count_o++;
    if (got !== expected) begin
      error_count_o++;
      test_errors++;
      $display("Error at %0d ns: %s is %0h, expected %0h", $time, what, got, expected);
    end
  endtask

  task automatic apply_expectation();
    logic [sim_mon_pkg::ID_W-1:0] id;
    id = exp_id_i[sim_mon_pkg::ID_W-1:0];
    case (exp_kind_i)
      8'h05: begin
        exp_line[id]  = {exp_a_i, exp_b_i};
        exp_len[id]   = line_length({exp_a_i, exp_b_i});
        line_pend[id] = 1'b1;
      end
      8'h06: begin
        check_value("sentinel count", 32'(sentinel_count_i), 32'(exp_a_i[23:16]));
        check_value("sync count", 32'(sync_count_i), 32'(exp_a_i[15:8]));
        check_value("fsync count", 32'(fsync_count_i), 32'(exp_a_i[7:0]));
      end
      8'h07: check_value("error code", 32'(err_code_i), 32'(exp_a_i[7:0]));
      8'h08: begin
        check_value("exit code", 32'(exit_code_i), 32'(exp_a_i[15:0]));
        check_value("eoc flag", 32'(eoc_i), 32'(exp_b_i[0]));
      end
      8'h09: check_value("overflow flag", 32'(overflow_i), 32'(exp_a_i[0]));
      8'h0A: begin
        // one nibble per drain with the first drain lowest
        check_value("drain count", 32'(order_cnt), 32'(exp_id_i));
        for (int i = 0; i < 8; i++) begin
          if (i < int'(exp_id_i)) begin
            check_value($sformatf("drain %0d id", i), 32'(order_log[i]),
                        32'(exp_a_i[i*4 +: 4]));
          end
        end
      end
      8'h0B: begin
        // a new sentinel must move the stamp
        check_count_o++;
        if (sentinel_time_i == '0 || sentinel_time_i == last_stamp) begin
          error_count_o++;
          test_errors++;
          $display("Error at %0d ns: sentinel stamp %0h did not move from %0h",
                   $time, sentinel_time_i, last_stamp);
        end
        last_stamp = sentinel_time_i;
      end
      8'h0E: begin
        // timer counts every cycle from zero after reset
        check_value("cycle timer", 32'(timer_i), 32'(elapsed));
        test_count_o++;
        if (test_errors == 0) begin
          $display("test %0d passed", exp_id_i);
        end else begin
          test_fail_o++;
          $display("test %0d failed with %0d errors", exp_id_i, test_errors);
        end
        test_errors = 0;
        order_cnt   = 0;
      end
      default: begin
        error_count_o++;
        test_errors++;
        $display("the pattern file holds an unknown expectation kind %0h", exp_kind_i);
      end
    endcase
  endtask

  always @(posedge clk) begin
    if (reset_i) begin
      for (int i = 0; i < sim_mon_pkg::N_IDS; i++) begin
        got_cnt[i] = 0;
        exp_len[i] = 0;
      end
      line_pend     = '0;
      order_cnt     = 0;
      prev_valid    = 1'b0;
      last_stamp    = '0;
      test_errors   = 0;
      elapsed       = 0;
      check_count_o = 0;
      error_count_o = 0;
      test_count_o  = 0;
      test_fail_o   = 0;
    end else begin
      if (line_valid_i) begin
        // rising valid marks a new drain
        if (!prev_valid && order_cnt < 8) begin
          order_log[order_cnt] = 4'(line_id_i);
          order_cnt++;
        end
        if (got_cnt[line_id_i] < sim_mon_pkg::LINE_DEPTH) begin
          got_mem[line_id_i][got_cnt[line_id_i]] = line_char_i;
          got_cnt[line_id_i]++;
        end else begin
          error_count_o++;
          test_errors++;
          $display("id %0d released more characters than one line can hold", line_id_i);
        end
      end
      prev_valid = line_valid_i;
      // compare once the whole line is in
      for (int id = 0; id < sim_mon_pkg::N_IDS; id++) begin
        if (line_pend[id] && got_cnt[id] >= exp_len[id]) begin
          for (int i = 0; i < exp_len[id]; i++) begin
            check_value($sformatf("line %0d character %0d", id, i), 32'(got_mem[id][i]),
                        32'(exp_line[id][(7-i)*8 +: 8]));
          end
          got_cnt[id]   = 0;
          line_pend[id] = 1'b0;
        end
      end
      if (exp_valid_i) begin
        apply_expectation();
      end
      elapsed++;
    end
  end

endmodule

// File: bench/sim_mon_tb.sv
// testbench top for the simulation monitor with clock, reset, pattern reader and stimulus driver
`timescale 1ns/1ps

module sim_mon_tb;

  logic                            clk;
  logic                            reset_i;
  // dut ports, named as on the dut
  logic                            aw_valid_i;
  logic [sim_mon_pkg::ADDR_W-1:0]  aw_addr_i;
  logic [sim_mon_pkg::ID_W-1:0]    aw_id_i;
  logic                            w_valid_i;
  logic [sim_mon_pkg::DATA_W-1:0]  w_data_i;
  logic                            instr_valid_i;
  logic [31:0]                     instr_i;
  logic                            line_valid_o;
  logic [7:0]                      line_char_o;
  logic [sim_mon_pkg::ID_W-1:0]    line_id_o;
  logic [sim_mon_pkg::CNT_W-1:0]   sentinel_count_o;
  logic [sim_mon_pkg::CNT_W-1:0]   sync_count_o;
  logic [sim_mon_pkg::CNT_W-1:0]   fsync_count_o;
  logic [7:0]                      err_code_o;
  logic [15:0]                     exit_code_o;
  logic                            eoc_o;
  logic                            overflow_o;
  logic [sim_mon_pkg::TIME_W-1:0]  timer_o;
  logic [sim_mon_pkg::TIME_W-1:0]  sentinel_time_o;
  // expectation bus to the checker
  logic        exp_valid;
  logic [7:0]  exp_kind;
  logic [7:0]  exp_id;
  logic [31:0] exp_a;
  logic [31:0] exp_b;
  logic        pending;
  int          check_count;
  int          error_count;
  int          test_count;
  int          test_fail;
  // each record is four words of kind, id, a and b
  logic [31:0] pat_mem [256];
  int          n_rec;
  int          limit;
  int          cycles;
  logic        file_ok;

  sim_mon_top sim_mon_top_inst (.*);

  sim_mon_checker sim_mon_checker_inst (
    .clk              (clk),
    .reset_i          (reset_i),
    .line_valid_i     (line_valid_o),
    .line_char_i      (line_char_o),
    .line_id_i        (line_id_o),
    .sentinel_count_i (sentinel_count_o),
    .sync_count_i     (sync_count_o),
    .fsync_count_i    (fsync_count_o),
    .err_code_i       (err_code_o),
    .exit_code_i      (exit_code_o),
    .eoc_i            (eoc_o),
    .overflow_i       (overflow_o),
    .timer_i          (timer_o),
    .sentinel_time_i  (sentinel_time_o),
    .exp_valid_i      (exp_valid),
    .exp_kind_i       (exp_kind),
    .exp_id_i         (exp_id),
    .exp_a_i          (exp_a),
    .exp_b_i          (exp_b),
    .pending_o        (pending),
    .check_count_o    (check_count),
    .error_count_o    (error_count),
    .test_count_o     (test_count),
    .test_fail_o      (test_fail)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // run limit scales with the number of records
  always @(posedge clk) begin
    if (reset_i) begin
      cycles <= 0;
    end else begin
      cycles <= cycles + 1;
      if (limit > 0 && cycles > limit) begin
        $display("timeout: the run did not finish within %0d cycles", limit);
        $display("SOME TESTS FAILED");
        $finish;
      end
    end
  end

  // at least one idle cycle, so 2-cycle status latency has passed
  task automatic idle_gap();
    repeat (1 + ($urandom % 3)) @(negedge clk);
  endtask

  // split puts the w beat one cycle after its aw
  task automatic send_beat(input logic [31:0] addr, input logic [sim_mon_pkg::ID_W-1:0] id,
                           input logic [31:0] data, input logic split);
    aw_valid_i = 1'b1;
    aw_addr_i  = addr;
    aw_id_i    = id;
    w_valid_i  = !split;
    w_data_i   = data;
    if (split) begin
      @(negedge clk);
      aw_valid_i = 1'b0;
      w_valid_i  = 1'b1;
    end
    @(negedge clk);
    aw_valid_i = 1'b0;
    w_valid_i  = 1'b0;
    idle_gap();
  endtask

  // one console write per nonzero byte, leftmost first
  task automatic send_string(input logic [sim_mon_pkg::ID_W-1:0] id, input logic [63:0] chars);
    for (int i = 7; i >= 0; i--) begin
      if (chars[i*8 +: 8] != 8'h00) begin
        send_beat(sim_mon_pkg::STDIO_ADDR, id, 32'(chars[i*8 +: 8]), 1'b0);
      end
    end
  endtask

  task automatic send_instr(input logic [31:0] word);
    instr_valid_i = 1'b1;
    instr_i       = word;
    @(negedge clk);
    instr_valid_i = 1'b0;
    idle_gap();
  endtask

  task automatic post_expect(input logic [31:0] kind, input logic [31:0] id,
                             input logic [31:0] a, input logic [31:0] b);
    exp_valid = 1'b1;
    exp_kind  = kind[7:0];
    exp_id    = id[7:0];
    exp_a     = a;
    exp_b     = b;
    @(negedge clk);
    exp_valid = 1'b0;
  endtask

  task automatic run_patterns();
    logic [31:0] kind;
    logic [31:0] id;
    logic [31:0] a;
    logic [31:0] b;
    for (int r = 0; r < n_rec; r++) begin
      kind = pat_mem[4*r];
      id   = pat_mem[4*r+1];
      a    = pat_mem[4*r+2];
      b    = pat_mem[4*r+3];
      case (kind)
        32'h01: send_beat(a, id[sim_mon_pkg::ID_W-1:0], b, 1'b0);
        32'h0C: send_beat(a, id[sim_mon_pkg::ID_W-1:0], b, 1'b1);
        32'h02: send_string(id[sim_mon_pkg::ID_W-1:0], {a, b});
        32'h03: send_instr(a);
        32'h04: repeat (a) @(negedge clk);
        32'h05: post_expect(kind, id, a, b);
        default: begin
          // outstanding lines finish first
          while (pending) @(negedge clk);
          post_expect(kind, id, a, b);
        end
      endcase
    end
  endtask

  initial begin
    void'($urandom(32'hdde3));
    reset_i       = 1'b1;
    aw_valid_i    = 1'b0;
    aw_addr_i     = '0;
    aw_id_i       = '0;
    w_valid_i     = 1'b0;
    w_data_i      = '0;
    instr_valid_i = 1'b0;
    instr_i       = '0;
    exp_valid     = 1'b0;
    exp_kind      = '0;
    exp_id        = '0;
    exp_a         = '0;
    exp_b         = '0;
    limit         = 0;
    n_rec         = 0;
    $readmemh("bench/sim_mon_patterns.txt", pat_mem);
    while (n_rec < 64 && pat_mem[4*n_rec] !== 32'hFF) n_rec++;
    file_ok = n_rec < 64;
    repeat (3) @(negedge clk);
    reset_i = 1'b0;
    if (!file_ok) begin
      $display("the pattern file could not be read or has no end record");
    end else begin
      limit = n_rec * 20;
      run_patterns();
    end
    while (pending) @(negedge clk);
    repeat (2) @(negedge clk);
    $display("tests %0d, failed tests %0d, checks %0d, errors %0d",
             test_count, test_fail, check_count, error_count);
    if (file_ok && test_count > 0 && test_fail == 0 && error_count == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

// File: bench/sim_mon_patterns.txt
// kind id a b: 01 write a=addr b=data, 0C split aw/w write, 02 console chars a:b, 03 instr a
// 04 wait a cycles, 05 line a:b, 06 counts a, 07 err a, 08 exit a eoc b, 09 ovfl a, 0A drains id=n a, 0B stamp moved, 0E test end, FF end
04 00 00000005 00000000
02 01 4869210A 00000000
05 01 4869210A 00000000
0A 01 00000001 00000000
09 00 00000000 00000000
0E 01 00000000 00000000
02 01 61000000 00000000
02 02 78000000 00000000
02 01 62000000 00000000
02 02 79000000 00000000
02 03 30313233 34353600
02 03 0A000000 00000000
02 02 0A000000 00000000
02 01 0A000000 00000000
05 01 61620A00 00000000
05 02 78790A00 00000000
05 03 30313233 3435360A
0A 03 00000213 00000000
0E 02 00000000 00000000
02 00 41424344 45464748
02 00 490A0000 00000000
05 00 41424344 45464748
09 00 00000001 00000000
0E 03 00000000 00000000
01 00 FFFF0000 0000005A
07 00 0000005A 00000000
0C 00 CC030000 00000000
08 00 00000000 00000000
0C 00 CC030000 00010003
08 00 00000003 00000001
07 00 0000005A 00000000
0E 04 00000000 00000000
03 00 50500013 00000000
0B 00 00000000 00000000
03 00 0063A2AF 00000000
03 00 0000005B 00000000
03 00 00500093 00000000
03 00 50500013 00000000
0B 00 00000000 00000000
03 00 0863A2AF 00000000
03 00 0000005B 00000000
03 00 0063B2AF 00000000
03 00 0063A2AF 00000000
03 00 50500093 00000000
03 00 50500013 00000000
0B 00 00000000 00000000
06 00 00030202 00000000
0E 05 00000000 00000000
FF 00 00000000 00000000

// File: sources.f
hdl/sim_mon_pkg.sv
hdl/write_decoder.sv
hdl/line_buffer.sv
hdl/instr_classifier.sv
hdl/status_regs.sv
hdl/sim_mon_top.sv
bench/sim_mon_checker.sv
bench/sim_mon_tb.sv

// File: run_sim.sh
#!/bin/sh
# build the monitor testbench with verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module sim_mon_tb -f sources.f -o sim_mon_tb \
  && ./obj_dir/sim_mon_tb > sim.log 2>&1 \
  || echo "build or simulation did not complete"
cat sim.log 2>/dev/null
grep -q "ALL TESTS PASSED" sim.log && echo "simulation passed" && exit 0
echo "simulation failed"
exit 1
